//--- source/tenyrPkg.sv
package tenyrPkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  regIdx_t;
    typedef logic [3:0]  aluOp_t;
    typedef logic [1:0]  opKind_t;

    typedef enum logic [2:0] {
        idle,
        issue,
        execute,
        memory,
        writeBack
    } coreState_t;

    // alu op codes.
    localparam aluOp_t opOr   = 4'h0;
    localparam aluOp_t opAnd  = 4'h1;
    localparam aluOp_t opAdd  = 4'h2;
    localparam aluOp_t opMul  = 4'h3;
    localparam aluOp_t opPack = 4'h4;
    localparam aluOp_t opShl  = 4'h5;
    localparam aluOp_t opLt   = 4'h6;
    localparam aluOp_t opEq   = 4'h7;
    localparam aluOp_t opGe   = 4'h8;
    localparam aluOp_t opAndn = 4'h9;
    localparam aluOp_t opXor  = 4'ha;
    localparam aluOp_t opSub  = 4'hb;
    localparam aluOp_t opOrn  = 4'hc;
    localparam aluOp_t opShr  = 4'hd;
    localparam aluOp_t opTest = 4'he; // nonzero bit test.
    localparam aluOp_t opShra = 4'hf;

endpackage

//--- source/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              wrEn,
    input  tenyrPkg::regIdx_t wrIdx,
    input  tenyrPkg::regIdx_t rdX,
    input  tenyrPkg::regIdx_t rdY,
    input  tenyrPkg::regIdx_t rdZ,
    input  tenyrPkg::word_t   wrData,
    input  tenyrPkg::word_t   pValue,
    output tenyrPkg::word_t   valX,
    output tenyrPkg::word_t   valY,
    output tenyrPkg::word_t   valZ
);
    import tenyrPkg::*;

    word_t regs [15];

    // r0 is zero, r15 is P.
    function automatic word_t readReg(input regIdx_t idx);
        case (idx)
            4'd0:    readReg = '0;
            4'd15:   readReg = pValue;
            default: readReg = regs[idx];
        endcase
    endfunction

    assign valX = readReg(rdX);
    assign valY = readReg(rdY);
    assign valZ = readReg(rdZ);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < 15; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrIdx != 4'd0 && wrIdx != 4'd15) begin
            regs[wrIdx] <= wrData;
        end
    end

endmodule

//--- source/insnDecode.sv
`timescale 1ns/1ps

module insnDecode (
    input  tenyrPkg::word_t   insn,
    output tenyrPkg::regIdx_t idxZ,
    output tenyrPkg::regIdx_t idxX,
    output tenyrPkg::regIdx_t idxY,
    output tenyrPkg::aluOp_t  op,
    input  tenyrPkg::word_t   valX,
    input  tenyrPkg::word_t   valY,
    output tenyrPkg::word_t   valA,
    output tenyrPkg::word_t   valB,
    output tenyrPkg::word_t   valC,
    output logic              storing,
    output logic              derefRhs
);
    import tenyrPkg::*;

    opKind_t kind;
    word_t   imm;

    assign kind     = insn[31:30];
    assign storing  = insn[29];
    assign derefRhs = insn[28];
    assign idxZ     = insn[27:24];

    // ##################################################
    // field split and immediate extension
    // ##################################################
    always_comb begin
        if (kind == 2'd3) begin
            idxX = '0;
            idxY = '0;
            op   = '0;
            imm  = {{8{insn[23]}}, insn[23:0]}; // wide immediate.
        end else begin
            idxX = insn[23:20];
            idxY = insn[19:16];
            op   = insn[15:12];
            imm  = {{20{insn[11]}}, insn[11:0]};
        end
    end

    // ##################################################
    // operand order by kind
    // ##################################################
    always_comb begin
        case (kind)
            2'd0:    {valA, valB, valC} = {valX, valY, imm};
            2'd1:    {valA, valB, valC} = {valX, imm, valY};
            2'd2:    {valA, valB, valC} = {imm, valX, valY};
            default: {valA, valB, valC} = {32'h0, 32'h0, imm};
        endcase
    end

endmodule

//--- source/execUnit.sv
`timescale 1ns/1ps

module execUnit (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             start,
    input  tenyrPkg::aluOp_t op,
    input  tenyrPkg::word_t  valA,
    input  tenyrPkg::word_t  valB,
    input  tenyrPkg::word_t  valC,
    output logic             done,
    output tenyrPkg::word_t  result
);
    import tenyrPkg::*;

    aluOp_t rOp;
    word_t  rA, rB, rC, rC2;
    word_t  rY, rZ;
    word_t  opOut;
    logic   v1, v2, v3; // stage valid bits.

    // op applied to the staged operands.
    always_comb begin
        case (rOp)
            opOr:   opOut = rA | rB;
            opAnd:  opOut = rA & rB;
            opAdd:  opOut = rA + rB;
            opMul:  opOut = rA * rB;
            opPack: opOut = {rA[19:0], rB[11:0]};
            opShl:  opOut = rA << rB;
            opLt:   opOut = {32{$signed(rA) < $signed(rB)}};
            opEq:   opOut = {32{rA == rB}};
            opGe:   opOut = {32{$signed(rA) >= $signed(rB)}};
            opAndn: opOut = rA & ~rB;
            opXor:  opOut = rA ^ rB;
            opSub:  opOut = rA - rB;
            opOrn:  opOut = rA | ~rB;
            opShr:  opOut = rA >> rB;
            opTest: opOut = {32{|(rA & (word_t'(1) << rB))}};
            opShra: opOut = $signed(rA) >>> rB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            v1   <= 1'b0;
            v2   <= 1'b0;
            v3   <= 1'b0;
            done <= 1'b0;
        end else begin
            v1   <= start;
            v2   <= v1;
            v3   <= v2;
            done <= v3;
        end
    end

    always_ff @(posedge clk) begin
        rOp    <= op;        // operand stage.
        rA     <= valA;
        rB     <= valB;
        rC     <= valC;
        rY     <= opOut;     // op stage.
        rC2    <= rC;
        rZ     <= rY + rC2;  // add stage.
        result <= rZ;
    end

endmodule

//--- source/coreSeq.sv
`timescale 1ns/1ps

module coreSeq (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            qValid,
    input  tenyrPkg::word_t qWord,
    output logic            qTake,
    input  logic            storeReady,
    input  tenyrPkg::word_t loadData,
    output logic            memWrite,
    output tenyrPkg::word_t memAddr,
    output tenyrPkg::word_t memData
);
    import tenyrPkg::*;

    coreState_t state;
    word_t      insnReg, resultReg, loadReg, pCount;
    word_t      curInsn, pValue, wrData, result;
    word_t      valX, valY, valZ, valA, valB, valC;
    regIdx_t    idxZ, idxX, idxY;
    aluOp_t     op;
    logic       storing, derefRhs, loading;
    logic       start, done, wrEn;

    // operands are read straight off the queue head during issue.
    assign curInsn = (state == issue) ? qWord : insnReg;
    assign qTake   = (state == issue);
    assign start   = (state == issue);
    assign loading = derefRhs & ~storing;

    // P as seen by an instruction already counts that instruction.
    assign pValue = qTake ? pCount + 32'd1 : pCount;

    assign memAddr  = derefRhs ? resultReg : valZ;
    assign memData  = derefRhs ? valZ : resultReg;
    assign memWrite = (state == memory) && storing && storeReady;

    assign wrEn   = (state == writeBack) && !storing;
    assign wrData = loading ? loadReg : resultReg;

    // ##################################################
    // sequencer
    // ##################################################
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state  <= idle;
            pCount <= 32'd1;
        end else begin
            case (state)
                idle:      if (qValid) state <= issue;
                issue: begin
                    state  <= execute;
                    pCount <= pCount + 32'd1;
                end
                execute:   if (done) state <= memory;
                memory:    if (!storing || storeReady) state <= writeBack; // store stall.
                writeBack: state <= qValid ? issue : idle;
                default:   state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == issue) insnReg <= qWord;
        if (done) resultReg <= result;
        if (state == memory) loadReg <= loadData;
    end

    insnDecode decode (
        .insn     (curInsn),
        .idxZ     (idxZ),
        .idxX     (idxX),
        .idxY     (idxY),
        .op       (op),
        .valX     (valX),
        .valY     (valY),
        .valA     (valA),
        .valB     (valB),
        .valC     (valC),
        .storing  (storing),
        .derefRhs (derefRhs)
    );

    execUnit exec (
        .clk     (clk),
        .reset_n (reset_n),
        .start   (start),
        .op      (op),
        .valA    (valA),
        .valB    (valB),
        .valC    (valC),
        .done    (done),
        .result  (result)
    );

    regFile regs (
        .clk     (clk),
        .reset_n (reset_n),
        .wrEn    (wrEn),
        .wrIdx   (idxZ),
        .rdX     (idxX),
        .rdY     (idxY),
        .rdZ     (idxZ),
        .wrData  (wrData),
        .pValue  (pValue),
        .valX    (valX),
        .valY    (valY),
        .valZ    (valZ)
    );

    // one instruction in flight at a time.
    doneInExecute: assert property (@(posedge clk) disable iff (!reset_n)
        done |-> state == execute);

endmodule

//--- source/insnQueue.sv
`timescale 1ns/1ps

module insnQueue #(
    parameter int queueDepth = 4
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            insnValid,
    input  tenyrPkg::word_t insnWord,
    input  logic            qTake,
    output logic            qValid,
    output tenyrPkg::word_t qWord,
    output logic            insnCredit
);
    import tenyrPkg::*;

    localparam int ptrW = (queueDepth > 1) ? $clog2(queueDepth) : 1;
    localparam int cntW = $clog2(queueDepth + 1);

    word_t           slots [queueDepth];
    logic [ptrW-1:0] wrPtr, rdPtr;
    logic [cntW-1:0] count;
    logic            pop;

    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        nextPtr = (ptr == ptrW'(queueDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign pop    = qTake && qValid;
    assign qValid = (count != '0);
    assign qWord  = slots[rdPtr];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            insnCredit <= 1'b0;
        end else begin
            if (insnValid) wrPtr <= nextPtr(wrPtr);
            if (pop) rdPtr <= nextPtr(rdPtr);
            if (insnValid && !pop) count <= count + 1'b1;
            else if (pop && !insnValid) count <= count - 1'b1;
            insnCredit <= pop; // one credit per dequeue.
        end
    end

    always_ff @(posedge clk) begin
        if (insnValid) slots[wrPtr] <= insnWord;
    end

    noPushWhenFull: assert property (@(posedge clk) disable iff (!reset_n)
        insnValid |-> count != cntW'(queueDepth));

endmodule

//--- source/storePort.sv
`timescale 1ns/1ps

module storePort #(
    parameter int scratchWords = 64,
    parameter int outCredits   = 2
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            memWrite,
    input  tenyrPkg::word_t memAddr,
    input  tenyrPkg::word_t memData,
    output tenyrPkg::word_t loadData,
    output logic            storeReady,
    output logic            storeValid,
    output tenyrPkg::word_t storeAddr,
    output tenyrPkg::word_t storeData,
    input  logic            storeCredit
);
    import tenyrPkg::*;

    localparam int addrW   = $clog2(scratchWords);
    localparam int creditW = $clog2(outCredits + 1);

    word_t              ram [scratchWords];
    logic [addrW-1:0]   index;
    logic [creditW-1:0] credits;

    assign index      = memAddr[addrW-1:0]; // wraps modulo scratchWords.
    assign loadData   = ram[index];
    assign storeReady = (credits != '0);

    // ##################################################
    // scratchpad
    // ##################################################
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < scratchWords; i++) begin
                ram[i] <= '0;
            end
        end else if (memWrite) begin
            ram[index] <= memData;
        end
    end

    // ##################################################
    // outgoing store stream
    // ##################################################
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            storeValid <= 1'b0;
            credits    <= creditW'(outCredits);
        end else begin
            storeValid <= memWrite;
            if (memWrite && !storeCredit) credits <= credits - 1'b1;
            else if (storeCredit && !memWrite) credits <= credits + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (memWrite) begin
            storeAddr <= memAddr;
            storeData <= memData;
        end
    end

    creditBound: assert property (@(posedge clk) disable iff (!reset_n)
        credits <= creditW'(outCredits));

endmodule

//--- source/tenyrTop.sv
`timescale 1ns/1ps

module tenyrTop #(
    parameter int queueDepth   = 4,
    parameter int scratchWords = 64,
    parameter int outCredits   = 2
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            insnValid,
    input  tenyrPkg::word_t insnWord,
    output logic            insnCredit,
    output logic            storeValid,
    output tenyrPkg::word_t storeAddr,
    output tenyrPkg::word_t storeData,
    input  logic            storeCredit
);
    import tenyrPkg::*;

    logic  qValid, qTake;
    word_t qWord;
    logic  storeReady, memWrite;
    word_t memAddr, memData, loadData;

    insnQueue #(
        .queueDepth (queueDepth)
    ) queue (
        .clk        (clk),
        .reset_n    (reset_n),
        .insnValid  (insnValid),
        .insnWord   (insnWord),
        .qTake      (qTake),
        .qValid     (qValid),
        .qWord      (qWord),
        .insnCredit (insnCredit)
    );

    coreSeq core (
        .clk        (clk),
        .reset_n    (reset_n),
        .qValid     (qValid),
        .qWord      (qWord),
        .qTake      (qTake),
        .storeReady (storeReady),
        .loadData   (loadData),
        .memWrite   (memWrite),
        .memAddr    (memAddr),
        .memData    (memData)
    );

    storePort #(
        .scratchWords (scratchWords),
        .outCredits   (outCredits)
    ) port (
        .clk         (clk),
        .reset_n     (reset_n),
        .memWrite    (memWrite),
        .memAddr     (memAddr),
        .memData     (memData),
        .loadData    (loadData),
        .storeReady  (storeReady),
        .storeValid  (storeValid),
        .storeAddr   (storeAddr),
        .storeData   (storeData),
        .storeCredit (storeCredit)
    );

endmodule

//--- tb/tenyrTb.sv
`timescale 1ns/1ps

module tenyrTb;
    import tenyrPkg::*;

    localparam int queueDepth     = 4;
    localparam int outCredits     = 2;
    localparam int resetCycles    = 16;
    localparam int maxGap         = 3;
    localparam int maxCreditDelay = 40;

    typedef struct packed {
        word_t insn;
        logic  expectStore;
        word_t addr;
        word_t data;
    } entry_t;

    logic  clk;
    logic  reset_n;
    logic  insnValid;
    word_t insnWord;
    logic  insnCredit;
    logic  storeValid;
    word_t storeAddr;
    word_t storeData;
    logic  storeCredit;

    entry_t entries [$];
    entry_t expStores [$];
    int sent           = 0; // instructions pushed.
    int creditsBack    = 0;
    int storesSeen     = 0;
    int creditsGiven   = 0; // storeCredit pulses.
    int creditsApplied = 0; // credits the store port has counted.
    int cycleCount     = 0;
    int timeoutLimit   = 0;
    logic creditPending = 1'b0;
    logic sourceStalled = 1'b0;

    tenyrTop DUT (
        .clk         (clk),
        .reset_n     (reset_n),
        .insnValid   (insnValid),
        .insnWord    (insnWord),
        .insnCredit  (insnCredit),
        .storeValid  (storeValid),
        .storeAddr   (storeAddr),
        .storeData   (storeData),
        .storeCredit (storeCredit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcgStep(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t wideInsn(input logic st, input logic dr, input regIdx_t z,
                                       input logic [23:0] imm);
        return {2'd3, st, dr, z, imm};
    endfunction

    function automatic word_t regInsn(input opKind_t kind, input logic st, input logic dr,
                                      input regIdx_t z, input regIdx_t x, input regIdx_t y,
                                      input aluOp_t op, input logic [11:0] imm);
        return {kind, st, dr, z, x, y, op, imm};
    endfunction

    task automatic addEntry(input word_t insn, input logic st, input word_t addr,
                            input word_t data);
        entry_t e;
        e = '{insn: insn, expectStore: st, addr: addr, data: data};
        entries.push_back(e);
        if (e.expectStore) expStores.push_back(e);
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic checkAddr(input word_t got, input word_t exp, input int idx);
        if (got !== exp) begin
            abortRun($sformatf("** Error at %0t ns: store %0d address %h, expected %h",
                               $time, idx, got, exp));
        end
    endtask

    task automatic checkData(input word_t got, input word_t exp, input int idx);
        if (got !== exp) begin
            abortRun($sformatf("** Error at %0t ns: store %0d data %h, expected %h",
                               $time, idx, got, exp));
        end
    endtask

    // ##################################################
    // program table
    // ##################################################
    // P reads as the entry number plus one.
    task automatic loadProgram();
        addEntry(wideInsn(1'b0, 1'b0, 4'd1, 24'hFFFFF0), 1'b0, 32'h0, 32'h0); // r1 = -16.
        addEntry(wideInsn(1'b0, 1'b0, 4'd2, 24'h000010), 1'b0, 32'h0, 32'h0);
        addEntry(regInsn(2'd0, 1'b1, 1'b0, 4'd2, 4'd1, 4'd0, opOr, 12'h000),
                 1'b1, 32'h10, 32'hFFFFFFF0);
        addEntry(wideInsn(1'b0, 1'b0, 4'd3, 24'h000005), 1'b0, 32'h0, 32'h0);
        addEntry(wideInsn(1'b0, 1'b0, 4'd4, 24'h000007), 1'b0, 32'h0, 32'h0);
        addEntry(regInsn(2'd0, 1'b1, 1'b0, 4'd2, 4'd3, 4'd4, opAdd, 12'h001),
                 1'b1, 32'h10, 32'h0000000D);
        addEntry(regInsn(2'd1, 1'b1, 1'b0, 4'd2, 4'd3, 4'd4, opSub, 12'h00A),
                 1'b1, 32'h10, 32'h00000002);
        addEntry(regInsn(2'd2, 1'b1, 1'b0, 4'd2, 4'd3, 4'd4, opMul, 12'hFFE),
                 1'b1, 32'h10, 32'hFFFFFFFD);
        addEntry(wideInsn(1'b1, 1'b0, 4'd2, 24'h000100), 1'b1, 32'h10, 32'h00000100);
        addEntry(regInsn(2'd0, 1'b1, 1'b0, 4'd2, 4'd4, 4'd3, opShl, 12'h000),
                 1'b1, 32'h10, 32'h000000E0);
        addEntry(regInsn(2'd0, 1'b1, 1'b0, 4'd2, 4'd1, 4'd3, opLt, 12'h003),
                 1'b1, 32'h10, 32'h00000002);
        addEntry(regInsn(2'd1, 1'b1, 1'b0, 4'd2, 4'd3, 4'd0, opTest, 12'h002),
                 1'b1, 32'h10, 32'hFFFFFFFF);
        addEntry(regInsn(2'd0, 1'b1, 1'b0, 4'd2, 4'd3, 4'd4, opEq, 12'h7FF),
                 1'b1, 32'h10, 32'h000007FF);
        addEntry(regInsn(2'd1, 1'b1, 1'b0, 4'd2, 4'd1, 4'd0, opShra, 12'h002),
                 1'b1, 32'h10, 32'hFFFFFFFC);
        // store r4 at 69, load back from 133, both land on word 5.
        addEntry(regInsn(2'd1, 1'b1, 1'b1, 4'd4, 4'd3, 4'd0, opAdd, 12'h040),
                 1'b1, 32'h45, 32'h00000007);
        addEntry(regInsn(2'd1, 1'b0, 1'b1, 4'd5, 4'd0, 4'd0, opAdd, 12'h085),
                 1'b0, 32'h0, 32'h0);
        addEntry(regInsn(2'd0, 1'b1, 1'b0, 4'd2, 4'd5, 4'd0, opOr, 12'h000),
                 1'b1, 32'h10, 32'h00000007);
        addEntry(wideInsn(1'b0, 1'b0, 4'd0, 24'h000123), 1'b0, 32'h0, 32'h0);  // dropped.
        addEntry(wideInsn(1'b0, 1'b0, 4'd15, 24'h000456), 1'b0, 32'h0, 32'h0); // dropped.
        addEntry(regInsn(2'd0, 1'b1, 1'b0, 4'd2, 4'd0, 4'd15, opAdd, 12'h000),
                 1'b1, 32'h10, 32'd21);
        addEntry(wideInsn(1'b1, 1'b0, 4'd15, 24'h0000AA), 1'b1, 32'd22, 32'h000000AA);
        addEntry(regInsn(2'd2, 1'b1, 1'b0, 4'd2, 4'd4, 4'd3, opPack, 12'h7FF),
                 1'b1, 32'h10, 32'h007FF00C);
        addEntry(regInsn(2'd0, 1'b1, 1'b0, 4'd5, 4'd3, 4'd4, opXor, 12'h000),
                 1'b1, 32'h07, 32'h00000002);
        addEntry(regInsn(2'd0, 1'b1, 1'b0, 4'd2, 4'd3, 4'd1, opGe, 12'h001),
                 1'b1, 32'h10, 32'h00000000);
    endtask

    task automatic sendProgram();
        logic [31:0] seed;
        int          gap;
        seed = 32'h74f9;
        for (int i = 0; i < entries.size(); i++) begin
            seed = lcgStep(seed);
            gap  = int'(seed >> 16) % (maxGap + 1);
            repeat (gap) @(posedge clk);
            while (queueDepth + creditsBack - sent <= 0) begin
                sourceStalled = 1'b1; // out of credits.
                @(posedge clk);
            end
            insnValid <= 1'b1;
            insnWord  <= entries[i].insn;
            sent++;
            @(posedge clk);
            insnValid <= 1'b0;
        end
    endtask

    initial begin
        reset_n   = 1'b0;
        insnValid = 1'b0;
        insnWord  = '0;
        loadProgram();
        timeoutLimit = resetCycles + entries.size() * (7 + maxGap + 2)
                     + expStores.size() * (maxCreditDelay + 3) + 200;
        repeat (resetCycles) @(posedge clk);
        reset_n <= 1'b1;
        sendProgram();
        wait (sent == entries.size() && storesSeen == expStores.size());
        repeat (20) @(posedge clk); // room for a stray store.
        if (creditsBack != sent) begin
            abortRun($sformatf("Run ended with %0d of %0d instructions taken off the queue",
                               creditsBack, sent));
        end else if (!sourceStalled) begin
            abortRun("The queue never filled, so the source never ran out of credits");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

    // ##################################################
    // downstream consumer and monitors
    // ##################################################
    initial begin : creditReturn
        logic [31:0] seed;
        int          delay;
        seed        = lcgStep(32'h74f9);
        storeCredit = 1'b0;
        forever begin
            @(posedge clk);
            if (storesSeen > creditsGiven) begin
                seed  = lcgStep(seed);
                delay = int'(seed >> 16) % (maxCreditDelay + 1);
                repeat (delay) @(posedge clk);
                storeCredit <= 1'b1;
                creditsGiven++;
                @(posedge clk);
                storeCredit <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (reset_n && insnCredit) begin
            creditsBack++;
            if (creditsBack > sent) abortRun("The queue returned more credits than it received words");
        end
        if (reset_n && storeValid) begin
            if (storesSeen >= expStores.size()) begin
                abortRun("A store appeared after every expected store had already arrived");
            end else if (outCredits + creditsApplied - storesSeen <= 0) begin
                abortRun("A store was sent while the consumer held back every credit");
            end else begin
                checkAddr(storeAddr, expStores[storesSeen].addr, storesSeen);
                checkData(storeData, expStores[storesSeen].data, storesSeen);
                storesSeen++;
            end
        end
        // the port counts a credit on the edge after it shows here.
        if (creditPending) creditsApplied++;
        creditPending = reset_n && storeCredit;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > timeoutLimit) begin
            abortRun($sformatf("Timeout after %0d cycles with %0d of %0d stores seen",
                               cycleCount, storesSeen, expStores.size()));
        end
    end

endmodule

//--- project.f
source/tenyrPkg.sv
source/regFile.sv
source/insnDecode.sv
source/execUnit.sv
source/coreSeq.sv
source/insnQueue.sv
source/storePort.sv
source/tenyrTop.sv
tb/tenyrTb.sv

//--- Makefile
TOP = tenyrTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
